// File: logic/clic_config.svh
//////////////////////////////////////////////////////////////////////
// CLIC subsystem sizes
// Source count and field widths shared by all CLIC blocks
//////////////////////////////////////////////////////////////////////

`ifndef CLIC_CONFIG_SVH
`define CLIC_CONFIG_SVH

// Number of level-sensitive interrupt sources
`define CLIC_NUM_SRC 16

// Width of a source id, log2 of the source count
`define CLIC_ID_WIDTH 4

// Width of an interrupt level, also used by mintthresh
`define CLIC_LVL_WIDTH 8

`endif

// File: logic/clic_pkg.sv
//////////////////////////////////////////////////////////////////////
// CLIC package
// Privilege encoding and machine trap state seen by the controller
//////////////////////////////////////////////////////////////////////

`include "clic_config.svh"

package clic_pkg;

  // Core privilege mode
  // Only user and machine exist here, encoded as in the RISC-V spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  //////////////////////////////////////////////////////////////////////
  // Machine trap state
  //////////////////////////////////////////////////////////////////////

  // Global machine interrupt enable and its stacked copy,
  // current interrupt level and its stacked copy, and the
  // software threshold below which interrupts are masked
  typedef struct packed {
    // mstatus.mie
    logic                       mie;
    // mstatus.mpie
    logic                       mpie;
    // mintstatus.mil
    logic [`CLIC_LVL_WIDTH-1:0] mil;
    // mcause.mpil
    logic [`CLIC_LVL_WIDTH-1:0] mpil;
    // mintthresh.th
    logic [`CLIC_LVL_WIDTH-1:0] mintthresh;
  } trap_state_t;

endpackage

// File: logic/clic_irq_if.sv
//////////////////////////////////////////////////////////////////////
// CLIC selected interrupt bundle
// Winning source from arbiter to controller, no handshake
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "clic_config.svh"

interface clic_irq_if;

  // A pending and enabled source exists
  logic                       irq;
  // Id and level of the winner
  logic [`CLIC_ID_WIDTH-1:0]  id;
  logic [`CLIC_LVL_WIDTH-1:0] level;
  // Winner uses hardware vectoring
  logic                       shv;

  // Arbiter side
  modport arb  (output irq, id, level, shv);
  // Controller side
  modport ctrl (input  irq, id, level, shv);

endinterface

// File: logic/clic_arbiter.sv
//////////////////////////////////////////////////////////////////////
// CLIC arbiter
// Per-source enable, level and shv registers with max-level select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "clic_config.svh"

module clic_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,

  // Level-sensitive sources
  input  logic [`CLIC_NUM_SRC-1:0]   irq_src_i,

  // Configuration write port, one source per write
  input  logic                       cfg_we_i,
  input  logic [`CLIC_ID_WIDTH-1:0]  cfg_id_i,
  input  logic                       cfg_en_i,
  input  logic [`CLIC_LVL_WIDTH-1:0] cfg_level_i,
  input  logic                       cfg_shv_i,

  // Selected interrupt to the controller
  clic_irq_if.arb                    sel
);

  // Source configuration
  logic [`CLIC_NUM_SRC-1:0]   en_q;
  logic [`CLIC_NUM_SRC-1:0]   shv_q;
  logic [`CLIC_LVL_WIDTH-1:0] level_q [`CLIC_NUM_SRC];

  // Pending and enabled sources
  logic [`CLIC_NUM_SRC-1:0]   cand;

  // Scan results
  logic                       found;
  logic [`CLIC_ID_WIDTH-1:0]  best_id;
  logic [`CLIC_LVL_WIDTH-1:0] best_level;

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  // All sources come out of reset disabled at level 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q    <= '0;
      shv_q   <= '0;
      level_q <= '{default: '0};
    end else if (cfg_we_i) begin
      // New settings are visible from the next edge
      en_q[cfg_id_i]    <= cfg_en_i;
      shv_q[cfg_id_i]   <= cfg_shv_i;
      level_q[cfg_id_i] <= cfg_level_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Max-level selection
  //////////////////////////////////////////////////////////////////////

  // Disabled sources never compete
  assign cand = irq_src_i & en_q;

  // Linear scan from id 0 upward
  // Using >= lets a later id take over on equal level
  always_comb begin
    found      = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int unsigned i = 0; i < `CLIC_NUM_SRC; i++) begin
      if (cand[i] && (!found || (level_q[i] >= best_level))) begin
        found      = 1'b1;
        best_id    = i[`CLIC_ID_WIDTH-1:0];
        best_level = level_q[i];
      end
    end
  end

  // Combinational result, follows the sources in the same cycle
  assign sel.irq   = found;
  assign sel.id    = best_id;
  assign sel.level = best_level;
  assign sel.shv   = shv_q[best_id];

  // The interface must only ever point at a live, enabled source
  a_sel_live : assert property (@(posedge clk) disable iff (!rst_n)
    sel.irq |-> (en_q[sel.id] && irq_src_i[sel.id]))
    else $error("arbiter selected id %0d which is not enabled and pending", sel.id);

endmodule

// File: logic/clic_int_controller.sv
//////////////////////////////////////////////////////////////////////
// CLIC interrupt controller
// Registers the winner and derives request, wake-up and mnxti status
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "clic_config.svh"

module clic_int_controller (
  input  logic                       clk,
  input  logic                       rst_n,

  // Selected interrupt from the arbiter
  clic_irq_if.ctrl                   sel,

  // Trap state and current mode of the core
  input  clic_pkg::trap_state_t      trap_i,
  input  clic_pkg::priv_lvl_e        priv_lvl_i,

  // To the core
  output logic                       irq_req_o,
  output logic [`CLIC_ID_WIDTH-1:0]  irq_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0] irq_level_o,
  output logic                       irq_shv_o,
  output logic                       irq_wu_o,

  // To the mnxti CSR
  output logic                       mnxti_pending_o,
  output logic [`CLIC_ID_WIDTH-1:0]  mnxti_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0] mnxti_level_o
);

  logic                       global_irq_enable;
  logic                       in_m_mode;
  logic [`CLIC_LVL_WIDTH-1:0] effective_level;

  // Registered copy of the selected interrupt
  logic                       irq_q;
  logic [`CLIC_ID_WIDTH-1:0]  id_q;
  logic [`CLIC_LVL_WIDTH-1:0] level_q;
  logic                       shv_q;

  //////////////////////////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////////////////////////

  // Valid bit tracks the arbiter every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= sel.irq;
    end
  end

  // Payload only loads while an interrupt is present,
  // so the last winner stays visible after its source drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_q    <= '0;
      level_q <= '0;
      shv_q   <= 1'b0;
    end else if (sel.irq) begin
      id_q    <= sel.id;
      level_q <= sel.level;
      shv_q   <= sel.shv;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Enable and level
  //////////////////////////////////////////////////////////////////////

  assign in_m_mode = (priv_lvl_i == clic_pkg::PRIV_LVL_M);

  // Machine interrupts always enabled from user mode
  assign global_irq_enable = trap_i.mie || !in_m_mode;

  // Larger of threshold and current level
  assign effective_level = (trap_i.mintthresh > trap_i.mil) ? trap_i.mintthresh : trap_i.mil;

  //////////////////////////////////////////////////////////////////////
  // Core outputs
  //////////////////////////////////////////////////////////////////////

  // In M mode the level must beat the effective level,
  // from U mode any nonzero level is enough
  assign irq_req_o = irq_q && global_irq_enable &&
                     (in_m_mode ? (level_q > effective_level) : (level_q != '0));

  // Wake-up uses the live selection so no clock is needed
  assign irq_wu_o = sel.irq &&
                    (in_m_mode ? (sel.level > effective_level) : (sel.level != '0));

  assign irq_id_o    = id_q;
  assign irq_level_o = level_q;
  assign irq_shv_o   = shv_q;

  //////////////////////////////////////////////////////////////////////
  // mnxti outputs
  //////////////////////////////////////////////////////////////////////

  // Ignores mie, compares against the stacked level instead of mil,
  // vectored interrupts are left to hardware
  assign mnxti_pending_o = irq_q &&
                           (level_q > trap_i.mpil) &&
                           (level_q > trap_i.mintthresh) &&
                           !shv_q;

  assign mnxti_id_o    = id_q;
  assign mnxti_level_o = level_q;

  // A request must never reach the core while M mode has interrupts off
  a_no_req_masked : assert property (@(posedge clk) disable iff (!rst_n)
    (in_m_mode && !trap_i.mie) |-> !irq_req_o)
    else $error("interrupt request raised in machine mode with mie clear");

endmodule

// File: logic/clic_trap_state.sv
//////////////////////////////////////////////////////////////////////
// CLIC machine trap state
// mie, mpie, mil, mpil and mintthresh updated on ack, mret and writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "clic_config.svh"

module clic_trap_state (
  input  logic                       clk,
  input  logic                       rst_n,

  // Strobes from the core
  input  logic                       irq_ack_i,
  input  logic                       mret_i,

  // Threshold CSR write
  input  logic                       thresh_we_i,
  input  logic [`CLIC_LVL_WIDTH-1:0] thresh_i,

  // Level of the interrupt being taken
  input  logic [`CLIC_LVL_WIDTH-1:0] irq_level_i,

  // Current state to the controller
  output clic_pkg::trap_state_t      trap_o
);

  clic_pkg::trap_state_t trap_q;
  clic_pkg::trap_state_t trap_d;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    trap_d = trap_q;

    // Trap entry pushes enable and level onto the one-deep stack
    if (irq_ack_i) begin
      trap_d.mpie = trap_q.mie;
      trap_d.mie  = 1'b0;
      trap_d.mpil = trap_q.mil;
      trap_d.mil  = irq_level_i;
    end else if (mret_i) begin
      // Trap return pops them back
      trap_d.mie  = trap_q.mpie;
      trap_d.mpie = 1'b1;
      trap_d.mil  = trap_q.mpil;
    end

    // Threshold is independent of the stack
    if (thresh_we_i) begin
      trap_d.mintthresh = thresh_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////////////////////////

  // mpie starts set, a first mret turns interrupts on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_q <= '{mie: 1'b0, mpie: 1'b1, mil: '0, mpil: '0, mintthresh: '0};
    end else begin
      trap_q <= trap_d;
    end
  end

  assign trap_o = trap_q;

  // Entry and return cannot retire in the same cycle
  a_ack_mret_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(irq_ack_i && mret_i))
    else $error("irq_ack_i and mret_i asserted together");

endmodule

// File: logic/clic_subsystem.sv
//////////////////////////////////////////////////////////////////////
// CLIC subsystem top
// Arbiter, interrupt controller and trap state wired together
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "clic_config.svh"

module clic_subsystem (
  input  logic                       clk,
  input  logic                       rst_n,

  // Interrupt sources
  input  logic [`CLIC_NUM_SRC-1:0]   irq_src_i,

  // Source configuration
  input  logic                       cfg_we_i,
  input  logic [`CLIC_ID_WIDTH-1:0]  cfg_id_i,
  input  logic                       cfg_en_i,
  input  logic [`CLIC_LVL_WIDTH-1:0] cfg_level_i,
  input  logic                       cfg_shv_i,

  // Threshold write
  input  logic                       thresh_we_i,
  input  logic [`CLIC_LVL_WIDTH-1:0] thresh_i,

  // Core status and strobes
  input  clic_pkg::priv_lvl_e        priv_lvl_i,
  input  logic                       irq_ack_i,
  input  logic                       mret_i,

  // Interrupt to the core
  output logic                       irq_req_o,
  output logic [`CLIC_ID_WIDTH-1:0]  irq_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0] irq_level_o,
  output logic                       irq_shv_o,
  output logic                       irq_wu_o,

  // mnxti status
  output logic                       mnxti_pending_o,
  output logic [`CLIC_ID_WIDTH-1:0]  mnxti_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0] mnxti_level_o
);

  // Winner from arbiter to controller
  clic_irq_if u_irq_if ();

  // Trap state back into the controller
  clic_pkg::trap_state_t trap;

  // Select
  clic_arbiter u_clic_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_src_i   (irq_src_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_id_i    (cfg_id_i),
    .cfg_en_i    (cfg_en_i),
    .cfg_level_i (cfg_level_i),
    .cfg_shv_i   (cfg_shv_i),
    .sel         (u_irq_if.arb)
  );

  // Decide
  clic_int_controller u_clic_int_controller (
    .clk             (clk),
    .rst_n           (rst_n),
    .sel             (u_irq_if.ctrl),
    .trap_i          (trap),
    .priv_lvl_i      (priv_lvl_i),
    .irq_req_o       (irq_req_o),
    .irq_id_o        (irq_id_o),
    .irq_level_o     (irq_level_o),
    .irq_shv_o       (irq_shv_o),
    .irq_wu_o        (irq_wu_o),
    .mnxti_pending_o (mnxti_pending_o),
    .mnxti_id_o      (mnxti_id_o),
    .mnxti_level_o   (mnxti_level_o)
  );

  // Commit, the taken level is the registered one the core saw
  clic_trap_state u_clic_trap_state (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_ack_i   (irq_ack_i),
    .mret_i      (mret_i),
    .thresh_we_i (thresh_we_i),
    .thresh_i    (thresh_i),
    .irq_level_i (irq_level_o),
    .trap_o      (trap)
  );

endmodule

// File: tb/tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 20 ns clock, reset held low for the first three cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // Half of the 20 ns period
  localparam int HALF_PERIOD_NS = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Three rising edges in reset, release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: tb/tb_clic_subsystem.sv
//////////////////////////////////////////////////////////////////////
// CLIC subsystem testbench
// Replays stimulus steps from a data file and checks every output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "clic_config.svh"

module tb_clic_subsystem;

  localparam int MAX_STEPS  = 64;
  localparam int NUM_FIELDS = 20;
  // Sample point inside the low phase after the falling edge
  localparam int SAMPLE_NS  = 5;

  logic                       clk;
  logic                       rst_n;

  // DUT inputs named as the ports
  logic [`CLIC_NUM_SRC-1:0]   irq_src_i;
  logic                       cfg_we_i;
  logic [`CLIC_ID_WIDTH-1:0]  cfg_id_i;
  logic                       cfg_en_i;
  logic [`CLIC_LVL_WIDTH-1:0] cfg_level_i;
  logic                       cfg_shv_i;
  logic                       thresh_we_i;
  logic [`CLIC_LVL_WIDTH-1:0] thresh_i;
  clic_pkg::priv_lvl_e        priv_lvl_i;
  logic                       irq_ack_i;
  logic                       mret_i;

  // DUT outputs
  logic                       irq_req_o;
  logic [`CLIC_ID_WIDTH-1:0]  irq_id_o;
  logic [`CLIC_LVL_WIDTH-1:0] irq_level_o;
  logic                       irq_shv_o;
  logic                       irq_wu_o;
  logic                       mnxti_pending_o;
  logic [`CLIC_ID_WIDTH-1:0]  mnxti_id_o;
  logic [`CLIC_LVL_WIDTH-1:0] mnxti_level_o;

  // One row per data line with 12 stimulus fields then 8 expected outputs
  int steps [MAX_STEPS][NUM_FIELDS];
  int num_steps     = 0;
  int cycle_count   = 0;
  int timeout_limit = 0;

  tb_clk_gen u_tb_clk_gen (.clk(clk), .rst_n(rst_n));

  clic_subsystem u_clic_subsystem (.*);

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  // Compare one output with field k of step n
  task automatic expect_field(input string name, input int n, input int k,
                              input logic [31:0] got);
    assert (got === 32'(steps[n][k]))
      else begin
        $display("Fail %s at step %0d: got 0x%0h, expected 0x%0h",
                 name, n + 1, got, steps[n][k]);
        stop_on_failure();
      end
  endtask

  task automatic load_steps();
    int fd;
    int nread;
    int k;
    int row [NUM_FIELDS];
    string line;
    fd = $fopen("tb/clic_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file tb/clic_testdata.txt");
      stop_on_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Blank lines and comment lines hold no step
        if (line.len() > 2 && line.substr(0, 1) != "//") begin
          nread = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          row[0], row[1], row[2], row[3], row[4], row[5], row[6],
                          row[7], row[8], row[9], row[10], row[11], row[12], row[13],
                          row[14], row[15], row[16], row[17], row[18], row[19]);
          if (nread != NUM_FIELDS || num_steps == MAX_STEPS) begin
            $display("Malformed or excess line in the test data file: %s", line);
            stop_on_failure();
          end else begin
            for (k = 0; k < NUM_FIELDS; k++) begin
              steps[num_steps][k] = row[k];
            end
            num_steps++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Drive on the falling edge, then let the step's idle edges pass
  task automatic apply_step(input int n);
    @(negedge clk);
    irq_src_i   = steps[n][0][`CLIC_NUM_SRC-1:0];
    cfg_we_i    = steps[n][1][0];
    cfg_id_i    = steps[n][2][`CLIC_ID_WIDTH-1:0];
    cfg_en_i    = steps[n][3][0];
    cfg_level_i = steps[n][4][`CLIC_LVL_WIDTH-1:0];
    cfg_shv_i   = steps[n][5][0];
    thresh_we_i = steps[n][6][0];
    thresh_i    = steps[n][7][`CLIC_LVL_WIDTH-1:0];
    priv_lvl_i  = clic_pkg::priv_lvl_e'(steps[n][8][1:0]);
    irq_ack_i   = steps[n][9][0];
    mret_i      = steps[n][10][0];
    // Strobes see only the first rising edge
    repeat (steps[n][11]) begin
      @(negedge clk);
      cfg_we_i    = 1'b0;
      thresh_we_i = 1'b0;
      irq_ack_i   = 1'b0;
      mret_i      = 1'b0;
    end
    #(SAMPLE_NS);
  endtask

  task automatic check_step(input int n);
    expect_field("irq_req_o", n, 12, irq_req_o);
    expect_field("irq_id_o", n, 13, irq_id_o);
    expect_field("irq_level_o", n, 14, irq_level_o);
    expect_field("irq_shv_o", n, 15, irq_shv_o);
    expect_field("irq_wu_o", n, 16, irq_wu_o);
    expect_field("mnxti_pending_o", n, 17, mnxti_pending_o);
    expect_field("mnxti_id_o", n, 18, mnxti_id_o);
    expect_field("mnxti_level_o", n, 19, mnxti_level_o);
  endtask

  // Run limit counted in rising edges
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, the steps did not complete", cycle_count);
      stop_on_failure();
    end
  end

  initial begin
    irq_src_i   = '0;
    cfg_we_i    = 1'b0;
    cfg_id_i    = '0;
    cfg_en_i    = 1'b0;
    cfg_level_i = '0;
    cfg_shv_i   = 1'b0;
    thresh_we_i = 1'b0;
    thresh_i    = '0;
    priv_lvl_i  = clic_pkg::PRIV_LVL_M;
    irq_ack_i   = 1'b0;
    mret_i      = 1'b0;
    load_steps();
    // At most three edges per step plus reset and margin
    timeout_limit = num_steps * 8 + 50;
    wait (rst_n === 1'b1);
    for (int n = 0; n < num_steps; n++) begin
      apply_step(n);
      check_step(n);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: tb/clic_testdata.txt
// src cfg_we cfg_id cfg_en cfg_level cfg_shv thresh_we thresh priv ack mret idle (hex)
// then expected: req id level shv wu mnxti_pending mnxti_id mnxti_level (hex)
0000 1 3 1 10 0 0 00 3 0 0 1   0 0 00 0 0 0 0 00
0008 0 0 0 00 0 0 00 3 0 0 2   0 3 10 0 1 1 3 10
0008 0 0 0 00 0 0 00 3 0 1 1   1 3 10 0 1 1 3 10
0088 1 7 1 20 0 0 00 3 0 0 2   1 7 20 0 1 1 7 20
1088 1 c 1 20 0 0 00 3 0 0 2   1 c 20 0 1 1 c 20
9088 1 f 0 40 0 0 00 3 0 0 2   1 c 20 0 1 1 c 20
9088 1 1 1 30 0 0 00 3 0 0 2   1 c 20 0 1 1 c 20
908a 0 0 0 00 0 0 00 3 0 0 1   1 1 30 0 1 1 1 30
0008 0 0 0 00 0 1 10 3 0 0 1   0 3 10 0 0 0 3 10
0008 1 3 1 18 0 0 00 3 0 0 2   1 3 18 0 1 1 3 18
0008 0 0 0 00 0 1 00 3 1 0 1   0 3 18 0 0 1 3 18
0080 0 0 0 00 0 0 00 3 0 0 1   0 7 20 0 1 1 7 20
0080 1 7 1 20 1 0 00 3 0 0 2   0 7 20 1 1 0 7 20
0000 0 0 0 00 0 0 00 3 0 1 1   0 7 20 1 0 0 7 20
0008 0 0 0 00 0 0 00 3 0 0 1   1 3 18 0 1 1 3 18
0008 0 0 0 00 0 1 ff 3 1 0 1   0 3 18 0 0 0 3 18
0008 0 0 0 00 0 0 00 0 0 0 1   1 3 18 0 1 0 3 18
0020 1 5 1 00 0 0 00 0 0 0 2   0 5 00 0 0 0 5 00
0000 0 0 0 00 0 1 00 3 0 1 1   0 5 00 0 0 0 5 00
0080 0 0 0 00 0 0 00 3 0 0 0   0 5 00 0 1 0 5 00
0080 0 0 0 00 0 0 00 3 0 0 1   1 7 20 1 1 0 7 20
0000 0 0 0 00 0 0 00 3 0 0 0   1 7 20 1 0 0 7 20
0000 0 0 0 00 0 0 00 3 0 0 1   0 7 20 1 0 0 7 20

// File: sources.f
+incdir+logic
logic/clic_pkg.sv
logic/clic_irq_if.sv
logic/clic_arbiter.sv
logic/clic_int_controller.sv
logic/clic_trap_state.sv
logic/clic_subsystem.sv
tb/tb_clk_gen.sv
tb/tb_clic_subsystem.sv
